// ==== Bender.yml ====
package:
  name: gf4_elim

export_include_dirs:
  - include

sources:
  - rtl/gf4_pkg.sv
  - rtl/elim_pkg.sv
  - rtl/row_skew.sv
  - rtl/pivot_cell.sv
  - rtl/update_cell.sv
  - rtl/elim_array.sv
  - rtl/row_deskew.sv
  - rtl/gf4_elim_top.sv
  - target: test
    files:
      - verification/gf4_elim_tb.sv

// ==== gf4_elim.f ====
+incdir+include
rtl/gf4_pkg.sv
rtl/elim_pkg.sv
rtl/row_skew.sv
rtl/pivot_cell.sv
rtl/update_cell.sv
rtl/elim_array.sv
rtl/row_deskew.sv
rtl/gf4_elim_top.sv
verification/gf4_elim_tb.sv

// ==== include/gf4_elim_cfg.svh ====
// array size and widths for the gf4 elimination array, included by every rtl source
`ifndef GF4_ELIM_CFG_SVH
`define GF4_ELIM_CFG_SVH

// array size, also rows per matrix
`define ELIM_N 4

// one gf(4) element
`define ELIM_ELEM_W 2

// one row, column 0 in the low bits
`define ELIM_ROW_W (`ELIM_N * `ELIM_ELEM_W)

// strobe in to res_valid out
`define ELIM_LAT (2 * `ELIM_N + 1)

`endif

// ==== rtl/elim_array.sv ====
// triangular systolic grid of pivot and update cells, drives the full-rank flag
`timescale 1ns/1ns
`include "gf4_elim_cfg.svh"

module elim_array (
  input  logic                clk,
  input  logic                rst_n,
  input  gf4_pkg::gf_row_t    col_elem,
  input  elim_pkg::row_kind_e col0_kind,
  output gf4_pkg::gf_row_t    bot_elem,
  output elim_pkg::row_kind_e bot_kind,
  output logic                full_rank
);

  import gf4_pkg::*;
  import elim_pkg::*;

  // outputs of cell (i,j); op, fac and kind only exist for j >= i
  wire gf_elem_t     elem_w [`ELIM_N][`ELIM_N];
  wire row_kind_e    kind_w [`ELIM_N][`ELIM_N];
  wire cell_op_e     op_w   [`ELIM_N][`ELIM_N];
  wire gf_elem_t     fac_w  [`ELIM_N][`ELIM_N];
  wire [`ELIM_N-1:0] holding;

  for (genvar i = 0; i < `ELIM_N; i++) begin : g_row
    wire gf_elem_t  elem_above [`ELIM_N];
    wire row_kind_e kind_above;

    if (i == 0) begin : g_top
      for (genvar j = 0; j < `ELIM_N; j++) begin : g_in
        assign elem_above[j] = col_elem[j];
      end
      assign kind_above = col0_kind;
    end else begin : g_below
      assign elem_above = elem_w[i-1];
      // kind comes from the cell right above the pivot
      assign kind_above = kind_w[i-1][i];
    end

    for (genvar j = 0; j < `ELIM_N; j++) begin : g_col
      if (j < i) begin : g_pass
        gf_elem_t pass_q;

        always_ff @(posedge clk) begin
          pass_q <= elem_above[j];
        end

        assign elem_w[i][j] = pass_q;
      end else if (j == i) begin : g_pivot
        pivot_cell u_pivot (
          .clk      (clk),
          .rst_n    (rst_n),
          .kind_in  (kind_above),
          .elem_in  (elem_above[j]),
          .op_out   (op_w[i][j]),
          .fac_out  (fac_w[i][j]),
          .kind_out (kind_w[i][j]),
          .elem_out (elem_w[i][j]),
          .holding  (holding[i])
        );
      end else begin : g_update
        update_cell u_update (
          .clk      (clk),
          .rst_n    (rst_n),
          .op_in    (op_w[i][j-1]),
          .fac_in   (fac_w[i][j-1]),
          .kind_in  (kind_w[i][j-1]),
          .elem_in  (elem_above[j]),
          .op_out   (op_w[i][j]),
          .fac_out  (fac_w[i][j]),
          .kind_out (kind_w[i][j]),
          .elem_out (elem_w[i][j])
        );
      end
    end
  end

  //////////////////////////////////////////////////
  // bottom edge and flag

  for (genvar j = 0; j < `ELIM_N; j++) begin : g_bot
    assign bot_elem[j] = elem_w[`ELIM_N-1][j];
  end

  assign bot_kind = kind_w[`ELIM_N-1][`ELIM_N-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_rank <= 1'b0;
    end else begin
      full_rank <= &holding;
    end
  end

endmodule

// ==== rtl/elim_pkg.sv ====
// opcode and row kind encodings shared by the array cells and the edge blocks
package elim_pkg;

  // opcode sent right along an array row
  typedef enum logic [2:0] {
    op_idle,
    op_load,
    op_elim,
    op_pass,
    op_drain
  } cell_op_e;

  // what a row carries through the array
  typedef enum logic [1:0] {
    kind_none,
    kind_data,
    kind_drain,
    kind_result
  } row_kind_e;

endpackage

// ==== rtl/gf4_elim_top.sv ====
// top level of the gf(4) triangularizer: skew stage, cell array and deskew stage
`timescale 1ns/1ns
`include "gf4_elim_cfg.svh"

module gf4_elim_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   row_valid,
  input  logic                   row_drain,
  input  logic [`ELIM_ROW_W-1:0] row_data,
  output logic                   res_valid,
  output logic [`ELIM_ROW_W-1:0] res_row,
  output logic                   full_rank
);

  import gf4_pkg::*;
  import elim_pkg::*;

  gf_row_t   col_elem;
  row_kind_e col0_kind;
  gf_row_t   bot_elem;
  row_kind_e bot_kind;

  row_skew u_skew (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_valid (row_valid),
    .row_drain (row_drain),
    .row_data  (row_data),
    .col_elem  (col_elem),
    .col0_kind (col0_kind)
  );

  elim_array u_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_elem  (col_elem),
    .col0_kind (col0_kind),
    .bot_elem  (bot_elem),
    .bot_kind  (bot_kind),
    .full_rank (full_rank)
  );

  row_deskew u_deskew (
    .clk       (clk),
    .rst_n     (rst_n),
    .bot_elem  (bot_elem),
    .bot_kind  (bot_kind),
    .res_valid (res_valid),
    .res_row   (res_row)
  );

endmodule

// ==== rtl/gf4_pkg.sv ====
// gf(4) element and row types plus field arithmetic, imported by the array rtl
`include "gf4_elim_cfg.svh"

package gf4_pkg;

  typedef logic [`ELIM_ELEM_W-1:0] gf_elem_t;

  // element 0 sits in the low bits
  typedef gf_elem_t [`ELIM_N-1:0] gf_row_t;

  //////////////////////////////////////////////////
  // field arithmetic, polynomial x^2 + x + 1

  // product reduced with x^2 = x + 1
  function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
    logic hi;
    logic mid;
    logic lo;
    hi  = a[1] & b[1];
    mid = (a[1] & b[0]) ^ (a[0] & b[1]);
    lo  = a[0] & b[0];
    return {mid ^ hi, lo ^ hi};
  endfunction

  // x and x+1 are each other's inverse, 0 maps to 0
  function automatic gf_elem_t gf_inv(input gf_elem_t a);
    gf_elem_t r;
    case (a)
      2'd2:    r = 2'd3;
      2'd3:    r = 2'd2;
      default: r = a;
    endcase
    return r;
  endfunction

endpackage

// ==== rtl/pivot_cell.sv ====
// diagonal array cell: keeps the pivot element and issues the opcode for its row
`timescale 1ns/1ns
`include "gf4_elim_cfg.svh"

module pivot_cell (
  input  logic                clk,
  input  logic                rst_n,
  input  elim_pkg::row_kind_e kind_in,
  input  gf4_pkg::gf_elem_t   elem_in,
  output elim_pkg::cell_op_e  op_out,
  output gf4_pkg::gf_elem_t   fac_out,
  output elim_pkg::row_kind_e kind_out,
  output gf4_pkg::gf_elem_t   elem_out,
  output logic                holding
);

  import gf4_pkg::*;
  import elim_pkg::*;

  gf_elem_t  kept_q;
  cell_op_e  op_d;
  row_kind_e kind_d;
  gf_elem_t  elem_d;
  gf_elem_t  fac_d;

  //////////////////////////////////////////////////
  // opcode decision

  always_comb begin
    op_d   = op_idle;
    kind_d = kind_none;
    elem_d = '0;
    fac_d  = '0;
    case (kind_in)
      kind_data: begin
        if (holding) begin
          // factor that cancels this column against the kept row
          op_d   = op_elim;
          kind_d = kind_data;
          fac_d  = gf_mul(elem_in, gf_inv(kept_q));
        end else if (elem_in != '0) begin
          op_d = op_load;
        end else begin
          op_d   = op_pass;
          kind_d = kind_data;
          elem_d = elem_in;
        end
      end
      kind_drain: begin
        if (holding) begin
          op_d   = op_drain;
          kind_d = kind_result;
          elem_d = kept_q;
        end else begin
          op_d   = op_pass;
          kind_d = kind_drain;
          elem_d = elem_in;
        end
      end
      kind_result: begin
        op_d   = op_pass;
        kind_d = kind_result;
        elem_d = elem_in;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      holding  <= 1'b0;
      op_out   <= op_idle;
      kind_out <= kind_none;
    end else begin
      if (op_d == op_load) begin
        holding <= 1'b1;
      end else if (op_d == op_drain) begin
        holding <= 1'b0;
      end
      op_out   <= op_d;
      kind_out <= kind_d;
    end
  end

  always_ff @(posedge clk) begin
    if (op_d == op_load) begin
      kept_q <= elem_in;
    end
    fac_out  <= fac_d;
    elem_out <= elem_d;
  end

  // a zero pivot would make the factor meaningless
  a_pivot_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n) holding |-> kept_q != '0
  );

endmodule

// ==== rtl/row_deskew.sv ====
// output stage: realigns the skewed bottom columns and flags result rows
`timescale 1ns/1ns
`include "gf4_elim_cfg.svh"

module row_deskew (
  input  logic                   clk,
  input  logic                   rst_n,
  input  gf4_pkg::gf_row_t       bot_elem,
  input  elim_pkg::row_kind_e    bot_kind,
  output logic                   res_valid,
  output logic [`ELIM_ROW_W-1:0] res_row
);

  import gf4_pkg::*;
  import elim_pkg::*;

  wire gf_row_t aligned;

  // column j waits N-1-j cycles, last column is already in line with the kind
  for (genvar j = 0; j < `ELIM_N; j++) begin : g_col
    if (j == `ELIM_N - 1) begin : g_last
      assign aligned[j] = bot_elem[j];
    end else begin : g_wait
      gf_elem_t pipe_q [`ELIM_N-1-j];

      always_ff @(posedge clk) begin
        pipe_q[0] <= bot_elem[j];
        for (int k = 1; k < `ELIM_N - 1 - j; k++) begin
          pipe_q[k] <= pipe_q[k-1];
        end
      end

      assign aligned[j] = pipe_q[`ELIM_N-2-j];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= (bot_kind == kind_result);
    end
  end

  always_ff @(posedge clk) begin
    res_row <= aligned;
  end

  // stays quiet through reset and the first cycle out of it
  a_quiet_reset : assert property (
    @(posedge clk) !rst_n |=> !res_valid
  );

endmodule

// ==== rtl/row_skew.sv ====
// input stage of the array: turns the strobes into a row kind and skews the columns
`timescale 1ns/1ns
`include "gf4_elim_cfg.svh"

module row_skew (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   row_valid,
  input  logic                   row_drain,
  input  logic [`ELIM_ROW_W-1:0] row_data,
  output gf4_pkg::gf_row_t       col_elem,
  output elim_pkg::row_kind_e    col0_kind
);

  import gf4_pkg::*;
  import elim_pkg::*;

  row_kind_e kind_d;
  row_kind_e kind_q;
  gf_row_t   row_q;

  always_comb begin
    if (row_valid) begin
      kind_d = kind_data;
    end else if (row_drain) begin
      kind_d = kind_drain;
    end else begin
      kind_d = kind_none;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kind_q <= kind_none;
    end else begin
      kind_q <= kind_d;
    end
  end

  // a drain carries an all-zero row
  always_ff @(posedge clk) begin
    row_q <= row_valid ? row_data : '0;
  end

  assign col0_kind = kind_q;

  //////////////////////////////////////////////////
  // staircase, column j waits j more cycles

  for (genvar j = 0; j < `ELIM_N; j++) begin : g_col
    if (j == 0) begin : g_direct
      assign col_elem[j] = row_q[j];
    end else begin : g_delay
      gf_elem_t pipe_q [j];

      always_ff @(posedge clk) begin
        pipe_q[0] <= row_q[j];
        for (int k = 1; k < j; k++) begin
          pipe_q[k] <= pipe_q[k-1];
        end
      end

      assign col_elem[j] = pipe_q[j-1];
    end
  end

  // one command per cycle at most
  a_one_strobe : assert property (
    @(posedge clk) disable iff (!rst_n) !(row_valid && row_drain)
  );

endmodule

// ==== rtl/update_cell.sv ====
// off-diagonal array cell: keeps one element of a pivot row and applies the opcodes
`timescale 1ns/1ns
`include "gf4_elim_cfg.svh"

module update_cell (
  input  logic                clk,
  input  logic                rst_n,
  input  elim_pkg::cell_op_e  op_in,
  input  gf4_pkg::gf_elem_t   fac_in,
  input  elim_pkg::row_kind_e kind_in,
  input  gf4_pkg::gf_elem_t   elem_in,
  output elim_pkg::cell_op_e  op_out,
  output gf4_pkg::gf_elem_t   fac_out,
  output elim_pkg::row_kind_e kind_out,
  output gf4_pkg::gf_elem_t   elem_out
);

  import gf4_pkg::*;
  import elim_pkg::*;

  gf_elem_t kept_q;
  gf_elem_t elem_d;

  // field addition is xor
  always_comb begin
    case (op_in)
      op_load:  elem_d = '0;
      op_elim:  elem_d = elem_in ^ gf_mul(fac_in, kept_q);
      op_drain: elem_d = kept_q;
      op_pass:  elem_d = elem_in;
      default:  elem_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (op_in == op_load) begin
      kept_q <= elem_in;
    end else if (op_in == op_drain) begin
      kept_q <= '0;
    end
    fac_out  <= fac_in;
    elem_out <= elem_d;
  end

  // op and kind move one cell right, kind also feeds the row below
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_out   <= op_idle;
      kind_out <= kind_none;
    end else begin
      op_out   <= op_in;
      kind_out <= kind_in;
    end
  end

endmodule

// ==== verification/gf4_elim_stimulus.txt ====
// one 3-digit hex word per command, first digit is the command, last two the argument
// 1 load row, 2 drain, 3 idle n cycles, 4 expect result row, 5 expect full_rank, f end of test n
// test 1: quiet after reset
308 500 f01
// test 2: full-rank matrix, third row passes array row 2 and lands in array row 3
179 1d6 12f 191 501
200 200 200 200 479 448 4a0 480 500 f02
// test 3: row 3 is row 0 plus row 1
1c6 125 15c 1e3 500
200 200 200 200 4c6 4a8 4a0 500 f03
// test 4: first row has zero in column 0
1b4 11b 14d 1e2 500
200 200 200 200 41b 4b4 460 500 f04
// test 5: rows loaded in reverse echelon order, then a second matrix right after the drains
140 1f0 1a8 155 200 200 200 200
1ad 149 1da 157 501
455 4a8 4f0 440
200 200 200 200 4ad 4e4 4b0 440 500 f05

// ==== verification/gf4_elim_tb.sv ====
// self-checking testbench for the gf(4) triangularizer, reads its commands from the stimulus file
`timescale 1ns/1ns
`include "gf4_elim_cfg.svh"

module gf4_elim_tb;

  localparam int STIM_DEPTH = 256;
  localparam int NUM_TESTS  = 5;

  logic                   clk;
  logic                   rst_n;
  logic                   row_valid;
  logic                   row_drain;
  logic [`ELIM_ROW_W-1:0] row_data;
  logic                   res_valid;
  logic [`ELIM_ROW_W-1:0] res_row;
  logic                   full_rank;

  logic [11:0]            stim_mem [STIM_DEPTH];
  logic [`ELIM_ROW_W-1:0] expected_q [$];
  logic [`ELIM_ROW_W-1:0] observed_q [$];
  int                     cmd_count;
  int                     cycle_limit;
  int                     cycle_cnt = 0;
  int                     test_errors;
  int                     tests_passed;
  int                     tests_failed;

  gf4_elim_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_valid (row_valid),
    .row_drain (row_drain),
    .row_data  (row_data),
    .res_valid (res_valid),
    .res_row   (res_row),
    .full_rank (full_rank)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // outputs change on the rising edge, so take them on the falling one
  always @(negedge clk) begin
    if (rst_n && res_valid) begin
      observed_q.push_back(res_row);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the stimulus did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // command helpers

  task automatic drive_cycle(input logic valid, input logic drain,
                             input logic [`ELIM_ROW_W-1:0] data);
    @(posedge clk);
    row_valid <= valid;
    row_drain <= drain;
    row_data  <= data;
  endtask

  task automatic idle_cycles(input int n);
    for (int k = 0; k < n; k++) begin
      drive_cycle(1'b0, 1'b0, '0);
    end
  endtask

  // full_rank settles within the array latency
  task automatic check_full_rank(input logic level);
    idle_cycles(`ELIM_LAT + 2);
    @(negedge clk);
    assert (full_rank === level) else begin
      $display("error at %0t ns: full_rank expected %0b, actual %0b", $time, level, full_rank);
      test_errors++;
    end
  endtask

  task automatic finish_test(input int num);
    logic [`ELIM_ROW_W-1:0] exp_row;
    logic [`ELIM_ROW_W-1:0] got_row;
    idle_cycles(`ELIM_LAT + 3);
    @(negedge clk);
    while (expected_q.size() > 0) begin
      exp_row = expected_q.pop_front();
      assert (observed_q.size() > 0) else begin
        $display("test %0d: result row %02h never came out of the array", num, exp_row);
        test_errors++;
      end
      if (observed_q.size() > 0) begin
        got_row = observed_q.pop_front();
        assert (got_row === exp_row) else begin
          $display("error at %0t ns: res_row expected %02h, actual %02h", $time, exp_row, got_row);
          test_errors++;
        end
      end
    end
    assert (observed_q.size() == 0) else begin
      $display("test %0d: %0d result rows came out that no drain asked for", num,
               observed_q.size());
      test_errors++;
      observed_q.delete();
    end
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d passed", num);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", num, test_errors);
    end
    test_errors = 0;
    idle_cycles($urandom % 4);
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    logic [11:0] cmd;
    void'($urandom(32'hbfbc));
    rst_n        = 1'b0;
    row_valid    = 1'b0;
    row_drain    = 1'b0;
    row_data     = '0;
    cycle_limit  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    $readmemh("verification/gf4_elim_stimulus.txt", stim_mem);
    cmd_count = 0;
    while (cmd_count < STIM_DEPTH && !$isunknown(stim_mem[cmd_count])) begin
      cmd_count++;
    end
    assert (cmd_count > 0) else begin
      $display("the stimulus file is missing or holds no commands");
      tests_failed++;
    end
    cycle_limit = (cmd_count + NUM_TESTS) * (`ELIM_LAT + 2) + 100;

    // outputs stay low while reset is held
    repeat (10) begin
      @(negedge clk);
      assert (res_valid === 1'b0) else begin
        $display("error at %0t ns: res_valid expected 0, actual %0b", $time, res_valid);
        test_errors++;
      end
      assert (full_rank === 1'b0) else begin
        $display("error at %0t ns: full_rank expected 0, actual %0b", $time, full_rank);
        test_errors++;
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;

    for (int idx = 0; idx < cmd_count; idx++) begin
      cmd = stim_mem[idx];
      case (cmd[11:8])
        4'h1: drive_cycle(1'b1, 1'b0, cmd[7:0]);
        4'h2: drive_cycle(1'b0, 1'b1, '0);
        4'h3: idle_cycles(cmd[7:0]);
        4'h4: expected_q.push_back(cmd[7:0]);
        4'h5: check_full_rank(cmd[0]);
        4'hf: finish_test(cmd[7:0]);
        default: begin
          $display("unknown command %03h at stimulus entry %0d", cmd, idx);
          test_errors++;
        end
      endcase
    end

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed == NUM_TESTS) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
